/* flist.f */
+incdir+hw
hw/jesd_link_pkg.sv
hw/jesd_sysref_capture.sv
hw/jesd_tx_link.sv
hw/jesd_rx_link.sv
hw/jesd_loopback_top.sv
bench/jesd_loopback_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the JESD loopback testbench with Verilator and runs it from the project root
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -f flist.f --top-module jesd_loopback_tb \
  -Mdir obj_dir -o jesd_loopback_sim

./obj_dir/jesd_loopback_sim | tee "$LOG"

if grep -q "TB FAILED" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi

echo "Simulation finished without failures"

/* bench/jesd_loopback_trace.txt */
// One entry per cycle as five hex digits: link_en, sysref, sysref_dly_sel, sync, lmfc_edge
// sync and lmfc_edge are the values expected at the start of the cycle, before its inputs
// Link up with select 00, SYSREF rises in entry 1
10000
11000
11000
11001
11010
10010
10010
10010
10010
10010
10010
10011
10010
// Select 01, SYSREF rises in entry 14
10110
11110
11110
11110
11111
// Select 10, SYSREF falls in entry 20
11210
11210
10210
10210
10211
10210
// Link enable dropped, then raised again
00210
00200
00200
00200
10200
10200
10201
10200
10210
10210
10210
10210
10210
10210
10211
10210
10210
10210
10210
10210
00210
00200

/* bench/jesd_loopback_tb.sv */
/* Testbench for the JESD link loopback
   Replays the cycle trace and checks sync, LMFC, transmit state and the data path */

`timescale 1ns/1ps
`default_nettype none

`include "jesd_link_consts.svh"

module jesd_loopback_tb
  import jesd_link_pkg::*;
();

  localparam int DW = `JESD_M * `JESD_NP;
  localparam int TRACE_MAX = 128;
  // Fill value that marks the entries the trace file did not reach
  localparam logic [19:0] TRACE_END = 20'hFFFFF;

  logic          device_clk;
  logic          arst_n;
  logic          sysref;
  logic [1:0]    sysref_dly_sel;
  logic          link_en;
  logic [DW-1:0] dac_data;
  wire  [DW-1:0] adc_data;
  wire           adc_valid;
  wire           sync;
  wire           lmfc_edge;
  wire           tx_active;

  // Digits are link_en, sysref, select, expected sync, expected lmfc_edge
  logic [19:0] trace [TRACE_MAX];

  logic [31:0] rng_state;
  int          mismatch_count;
  int          other_count;

  // Expected transmit state during the current cycle
  tx_state_t     model_state;
  // Expected tx_active and driven dac_data one and two cycles back
  logic          tx_d1;
  logic          tx_d2;
  logic [DW-1:0] dac_d1;
  logic [DW-1:0] dac_d2;

  jesd_loopback_top dut0 (
    .device_clk     (device_clk),
    .arst_n         (arst_n),
    .sysref         (sysref),
    .sysref_dly_sel (sysref_dly_sel),
    .link_en        (link_en),
    .dac_data       (dac_data),
    .adc_data       (adc_data),
    .adc_valid      (adc_valid),
    .sync           (sync),
    .lmfc_edge      (lmfc_edge),
    .tx_active      (tx_active)
  );

  always #5 device_clk = ~device_clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_mismatch(input string name, input logic [DW-1:0] exp_val,
                                 input logic [DW-1:0] act_val);
    $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
             $time, name, exp_val, act_val);
    mismatch_count++;
  endtask

  // Data leaves the receiver two cycles after the transmitter framed it
  task automatic check_adc_output();
    if (adc_valid !== tx_d2) begin
      report_mismatch("adc_valid", DW'(tx_d2), DW'(adc_valid));
    end
    if (tx_d2 && adc_data !== dac_d2) begin
      report_mismatch("adc_data", dac_d2, adc_data);
    end
  endtask

  // ******************************
  // One trace cycle
  // ******************************

  // Runs on the falling edge and checks what the last rising edge produced
  // before it drives the next inputs
  task automatic run_cycle(input logic [19:0] entry);
    logic          exp_tx;
    logic          link_up;
    logic [DW-1:0] next_dac;
    exp_tx = (model_state == DATA);
    if (sync !== entry[4]) begin
      report_mismatch("sync", DW'(entry[4]), DW'(sync));
    end
    if (lmfc_edge !== entry[0]) begin
      report_mismatch("lmfc_edge", DW'(entry[0]), DW'(lmfc_edge));
    end
    if (tx_active !== exp_tx) begin
      report_mismatch("tx_active", DW'(exp_tx), DW'(tx_active));
      $display("  expected transmit state %s", model_state.name());
    end
    check_adc_output();

    link_en        = entry[16];
    sysref         = entry[12];
    sysref_dly_sel = entry[9:8];
    rng_state      = xorshift32(rng_state);
    next_dac[31:0] = rng_state;
    rng_state      = xorshift32(rng_state);
    next_dac[DW-1:32] = rng_state;
    dac_data       = next_dac;

    tx_d2  = tx_d1;
    tx_d1  = exp_tx;
    dac_d2 = dac_d1;
    dac_d1 = next_dac;

    // The transmit state for the next cycle follows from the expected sync and LMFC of this one
    link_up = entry[16] & entry[4];
    case (model_state)
      CGS: begin
        if (link_up) begin
          model_state = WAIT_LMFC;
        end
      end
      WAIT_LMFC: begin
        if (!link_up) begin
          model_state = CGS;
        end else if (entry[0]) begin
          model_state = DATA;
        end
      end
      default: begin
        if (!link_up) begin
          model_state = CGS;
        end
      end
    endcase
  endtask

  // ******************************
  // Main sequence
  // ******************************

  initial begin
    int n;
    int wait_cycles;
    device_clk     = 1'b0;
    arst_n         = 1'b0;
    sysref         = 1'b0;
    sysref_dly_sel = 2'b00;
    link_en        = 1'b0;
    dac_data       = '0;
    rng_state      = 32'h5;
    mismatch_count = 0;
    other_count    = 0;
    model_state    = CGS;
    tx_d1          = 1'b0;
    tx_d2          = 1'b0;
    dac_d1         = '0;
    dac_d2         = '0;

    for (int i = 0; i < TRACE_MAX; i++) begin
      trace[i] = TRACE_END;
    end
    $readmemh("bench/jesd_loopback_trace.txt", trace);
    if (trace[0] === TRACE_END) begin
      $display("The trace file bench/jesd_loopback_trace.txt gave no entries");
      other_count++;
    end

    repeat (2) @(posedge device_clk);
    @(negedge device_clk);

    // Reset values before release
    if (sync !== 1'b0) begin
      report_mismatch("sync", '0, DW'(sync));
    end
    if (adc_valid !== 1'b0) begin
      report_mismatch("adc_valid", '0, DW'(adc_valid));
    end
    if (tx_active !== 1'b0) begin
      report_mismatch("tx_active", '0, DW'(tx_active));
    end
    if (lmfc_edge !== 1'b0) begin
      report_mismatch("lmfc_edge", '0, DW'(lmfc_edge));
    end
    if (adc_data !== '0) begin
      report_mismatch("adc_data", '0, adc_data);
    end
    arst_n = 1'b1;

    n = 0;
    while (n < TRACE_MAX && trace[n] !== TRACE_END) begin
      run_cycle(trace[n]);
      n++;
      @(negedge device_clk);
    end

    // The trace ends with link_en low, so the link must wind down
    // The last data beats still leave the receiver while it does
    wait_cycles = 0;
    while ((tx_active || adc_valid) && wait_cycles < 16) begin
      check_adc_output();
      tx_d2  = tx_d1;
      tx_d1  = (model_state == DATA);
      dac_d2 = dac_d1;
      @(negedge device_clk);
      wait_cycles++;
    end
    if (tx_active || adc_valid) begin
      $display("Timeout: tx_active or adc_valid still high %0d cycles after link_en fell",
               wait_cycles);
      other_count++;
    end
    if (sync !== 1'b0) begin
      report_mismatch("sync", '0, DW'(sync));
    end

    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/jesd_loopback_top.sv */
/* JESD link loopback top level
   SYSREF capture and LMFC feed a transmit link looped into a receive link */

`timescale 1ns/1ps
`default_nettype none

`include "jesd_link_consts.svh"

module jesd_loopback_top
  import jesd_link_pkg::*;
(
  input  wire                              device_clk,
  input  wire                              arst_n,
  input  wire                              sysref,
  input  wire  [1:0]                       sysref_dly_sel,
  input  wire                              link_en,
  input  wire  [`JESD_M*`JESD_NP-1:0]      dac_data,
  output wire  [`JESD_M*`JESD_NP-1:0]      adc_data,
  output wire                              adc_valid,
  output wire                              sync,
  output wire                              lmfc_edge,
  output wire                              tx_active
);

  // Lane words go straight from the framer to the deframer
  wire lane_word_t [`JESD_L-1:0] lane_data;

  // ******************************
  // SYSREF and LMFC
  // ******************************

  // Both links share the one multiframe clock
  // Only the edge pulse is needed here, the phase count stays inside
  jesd_sysref_capture sysref_capture0 (
    .device_clk     (device_clk),
    .arst_n         (arst_n),
    .sysref         (sysref),
    .sysref_dly_sel (sysref_dly_sel),
    .lmfc_edge      (lmfc_edge),
    .lmfc_count     ()
  );

  // ******************************
  // Transmit and receive links
  // ******************************

  jesd_tx_link tx_link0 (
    .device_clk (device_clk),
    .arst_n     (arst_n),
    .link_en    (link_en),
    .sync       (sync),
    .lmfc_edge  (lmfc_edge),
    .dac_data   (dac_data),
    .lane_data  (lane_data),
    .tx_active  (tx_active)
  );

  // Sync from the receiver closes the loop back to the transmitter
  jesd_rx_link rx_link0 (
    .device_clk (device_clk),
    .arst_n     (arst_n),
    .link_en    (link_en),
    .lane_data  (lane_data),
    .sync       (sync),
    .adc_data   (adc_data),
    .adc_valid  (adc_valid)
  );

endmodule

`default_nettype wire

/* hw/jesd_rx_link.sv */
/* JESD receive link
   Detects code-group sync, drives sync and deframes lanes into channels */

`timescale 1ns/1ps
`default_nettype none

`include "jesd_link_consts.svh"

module jesd_rx_link
  import jesd_link_pkg::*;
(
  input  wire                                device_clk,
  input  wire                                arst_n,
  input  wire                                link_en,
  input  wire  lane_word_t [`JESD_L-1:0]     lane_data,
  output logic                               sync,
  output logic [`JESD_M*`JESD_NP-1:0]        adc_data,
  output logic                               adc_valid
);

  // Samples carried by one lane in one beat
  localparam int SPL = `JESD_M / `JESD_L;
  // Octets in one lane word
  localparam int OCTETS = `LANE_BITS / 8;
  // Width of the code-group-sync word counter
  localparam int CNT_W = $clog2(`CGS_WORDS + 1);
  localparam logic [CNT_W-1:0] CGS_LAST = CNT_W'(`CGS_WORDS - 1);

  // One flag per lane for a word made only of K characters
  logic [`JESD_L-1:0] lane_is_k;
  // All lanes carry K in this beat
  logic all_k;

  // Consecutive all-K words seen so far
  logic [CNT_W-1:0] cgs_cnt;
  // Sync one beat late
  logic sync_q;

  // Current beat carries converter data
  logic data_beat;
  // Lane samples put back into channel order
  logic [`JESD_M*`JESD_NP-1:0] deframed;

  // ******************************
  // K character detection
  // ******************************

  always_comb begin
    for (int l = 0; l < `JESD_L; l++) begin
      lane_is_k[l] = 1'b1;
      for (int o = 0; o < OCTETS; o++) begin
        if (lane_data[l].octets[o] != `K_CHAR) begin
          lane_is_k[l] = 1'b0;
        end
      end
    end
  end

  // Lanes are taken in a fixed order with no deskew between them
  assign all_k = &lane_is_k;

  // ******************************
  // Code-group sync
  // ******************************

  // Any word that is not all K restarts the count before sync
  // Once up, sync is only dropped by the link enable
  always_ff @(posedge device_clk or negedge arst_n) begin
    if (!arst_n) begin
      cgs_cnt <= '0;
      sync    <= 1'b0;
      sync_q  <= 1'b0;
    end else begin
      sync_q <= sync;
      if (!link_en) begin
        cgs_cnt <= '0;
        sync    <= 1'b0;
      end else if (!sync) begin
        if (all_k) begin
          if (cgs_cnt == CGS_LAST) begin
            sync <= 1'b1;
          end else begin
            cgs_cnt <= cgs_cnt + CNT_W'(1);
          end
        end else begin
          cgs_cnt <= '0;
        end
      end
    end
  end

  // ******************************
  // Deframer
  // ******************************

  // The transmitter still sends its last data beat one cycle after sync
  // falls, so the delayed sync keeps that beat in the stream
  assign data_beat = (sync | sync_q) & ~all_k;

  // Sample slot s of lane l belongs to channel l*SPL + s
  always_comb begin
    for (int l = 0; l < `JESD_L; l++) begin
      for (int s = 0; s < SPL; s++) begin
        deframed[(l*SPL + s)*`JESD_NP +: `JESD_NP] = lane_data[l].samples[s];
      end
    end
  end

  // Channel data keeps its last value between data beats
  always_ff @(posedge device_clk or negedge arst_n) begin
    if (!arst_n) begin
      adc_valid <= 1'b0;
      adc_data  <= '0;
    end else begin
      adc_valid <= data_beat;
      if (data_beat) begin
        adc_data <= deframed;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/jesd_tx_link.sv */
/* JESD transmit link
   Sends code-group sync until sync, aligns to the LMFC and frames samples */

`timescale 1ns/1ps
`default_nettype none

`include "jesd_link_consts.svh"

module jesd_tx_link
  import jesd_link_pkg::*;
(
  input  wire                                device_clk,
  input  wire                                arst_n,
  input  wire                                link_en,
  input  wire                                sync,
  input  wire                                lmfc_edge,
  input  wire  [`JESD_M*`JESD_NP-1:0]        dac_data,
  output lane_word_t [`JESD_L-1:0]           lane_data,
  output logic                               tx_active
);

  // Samples carried by one lane in one beat
  localparam int SPL = `JESD_M / `JESD_L;
  // Octets in one lane word
  localparam int OCTETS = `LANE_BITS / 8;

  tx_state_t state;
  tx_state_t state_nxt;

  // Receiver in sync and link enabled
  logic link_up;

  // Lane words for the current beat in both modes
  lane_word_t [`JESD_L-1:0] cgs_word;
  lane_word_t [`JESD_L-1:0] framed;

  assign link_up = sync & link_en;

  // ******************************
  // State machine
  // ******************************

  always_comb begin
    state_nxt = state;
    case (state)
      CGS: begin
        if (link_up) begin
          state_nxt = WAIT_LMFC;
        end
      end
      WAIT_LMFC: begin
        // Data may only start on a multiframe boundary
        if (!link_up) begin
          state_nxt = CGS;
        end else if (lmfc_edge) begin
          state_nxt = DATA;
        end
      end
      DATA: begin
        // Loss of sync or of the enable drops back to code-group sync
        if (!link_up) begin
          state_nxt = CGS;
        end
      end
      default: begin
        state_nxt = CGS;
      end
    endcase
  end

  always_ff @(posedge device_clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= CGS;
    end else begin
      state <= state_nxt;
    end
  end

  assign tx_active = (state == DATA);

  // ******************************
  // Framer
  // ******************************

  // Every octet of every lane carries the K character during sync
  // Lane l takes channels 2l and 2l+1 into sample slots 0 and 1
  always_comb begin
    for (int l = 0; l < `JESD_L; l++) begin
      for (int o = 0; o < OCTETS; o++) begin
        cgs_word[l].octets[o] = `K_CHAR;
      end
      for (int s = 0; s < SPL; s++) begin
        framed[l].samples[s] = dac_data[(l*SPL + s)*`JESD_NP +: `JESD_NP];
      end
    end
  end

  // Lane words follow the state one beat later
  // WAIT_LMFC keeps sending K so the receiver stays in sync
  always_ff @(posedge device_clk) begin
    if (state == DATA) begin
      lane_data <= framed;
    end else begin
      lane_data <= cgs_word;
    end
  end

endmodule

`default_nettype wire

/* hw/jesd_sysref_capture.sv */
/* SYSREF capture with selectable delay or inversion
   Detects the captured SYSREF edge and runs the local multiframe clock */

`timescale 1ns/1ps
`default_nettype none

`include "jesd_link_consts.svh"

module jesd_sysref_capture (
  input  wire                              device_clk,
  input  wire                              arst_n,
  input  wire                              sysref,
  input  wire  [1:0]                       sysref_dly_sel,
  output logic                             lmfc_edge,
  output logic [$clog2(`LMFC_BEATS)-1:0]   lmfc_count
);

  localparam int CNT_W = $clog2(`LMFC_BEATS);
  localparam logic [CNT_W-1:0] LMFC_LAST = CNT_W'(`LMFC_BEATS - 1);

  // SYSREF delayed by one beat for select 01
  logic sysref_d;
  // SYSREF after the delay or inversion mux
  logic sysref_s;
  // Registered copy of the selected SYSREF and its previous value
  logic sysref_q;
  logic sysref_q_prev;
  // Single beat pulse on a rising edge of the registered SYSREF
  logic sysref_rise;
  // Set by the first captured edge and kept until reset
  logic lmfc_run;

  // ******************************
  // SYSREF selection
  // ******************************

  always_ff @(posedge device_clk or negedge arst_n) begin
    if (!arst_n) begin
      sysref_d <= 1'b0;
    end else begin
      sysref_d <= sysref;
    end
  end

  // 00 and 11 pass SYSREF through, 01 adds one beat, 10 inverts it
  always_comb begin
    case (sysref_dly_sel)
      2'b00:   sysref_s = sysref;
      2'b01:   sysref_s = sysref_d;
      2'b10:   sysref_s = ~sysref;
      default: sysref_s = sysref;
    endcase
  end

  // ******************************
  // Edge detection
  // ******************************

  always_ff @(posedge device_clk or negedge arst_n) begin
    if (!arst_n) begin
      sysref_q      <= 1'b0;
      sysref_q_prev <= 1'b0;
    end else begin
      sysref_q      <= sysref_s;
      sysref_q_prev <= sysref_q;
    end
  end

  assign sysref_rise = sysref_q & ~sysref_q_prev;

  // ******************************
  // LMFC counter
  // ******************************

  // Every captured edge restarts the count, so a moved SYSREF realigns the LMFC
  // The edge pulse is high whenever the count is at zero
  always_ff @(posedge device_clk or negedge arst_n) begin
    if (!arst_n) begin
      lmfc_run   <= 1'b0;
      lmfc_count <= '0;
      lmfc_edge  <= 1'b0;
    end else if (sysref_rise) begin
      lmfc_run   <= 1'b1;
      lmfc_count <= '0;
      lmfc_edge  <= 1'b1;
    end else if (lmfc_run) begin
      lmfc_edge  <= (lmfc_count == LMFC_LAST);
      lmfc_count <= (lmfc_count == LMFC_LAST) ? '0 : lmfc_count + CNT_W'(1);
    end else begin
      // No SYSREF seen yet so the multiframe clock stays idle
      lmfc_edge  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* hw/jesd_link_pkg.sv */
/* Shared types of the JESD loopback link
   Lane word union and transmit state encoding */

`default_nettype none

`include "jesd_link_consts.svh"

package jesd_link_pkg;

  // ******************************
  // Lane word
  // ******************************

  // One lane beat seen in two ways
  // The octet view is used to generate and detect K characters
  // The sample view is used by the framer and the deframer
  // Sample slot 0 holds the even channel of the lane and slot 1 the odd one
  typedef union packed {
    logic [`LANE_BITS/8-1:0][7:0]                   octets;
    logic [`LANE_BITS/`JESD_NP-1:0][`JESD_NP-1:0]    samples;
  } lane_word_t;

  // ******************************
  // Transmit link states
  // ******************************

  // CGS sends K characters until the receiver raises sync
  // WAIT_LMFC holds off data until the next multiframe boundary
  // DATA streams framed samples
  typedef enum logic [1:0] {
    CGS       = 2'd0,
    WAIT_LMFC = 2'd1,
    DATA      = 2'd2
  } tx_state_t;

endpackage

`default_nettype wire

/* hw/jesd_link_consts.svh */
/* JESD loopback link constants
   Converter geometry, lane layout and code-group-sync timing */

`ifndef JESD_LINK_CONSTS_SVH
`define JESD_LINK_CONSTS_SVH

// ******************************
// Converter geometry
// ******************************

// Number of converter channels in the link
`define JESD_M 4
// Number of lanes that carry the channels
`define JESD_L 2
// Width of one converter sample in bits
`define JESD_NP 16

// ******************************
// Lane word and timing
// ******************************

// Width of one lane word per beat, two samples or four octets
`define LANE_BITS 32
// Local multiframe clock period in beats
`define LMFC_BEATS 8
// All-K words in a row that the receiver needs before it raises sync
`define CGS_WORDS 4
// Code-group-sync character (K28.5 in 8b/10b terms)
`define K_CHAR 8'hBC

`endif
